/* logic/pitaya_defs.svh */
`ifndef PITAYA_DEFS_SVH
`define PITAYA_DEFS_SVH

//////////////////////////////
// Stream widths
//////////////////////////////
`define ADC_RAW_W 16   // ADC word incl. 2 reserved LSBs
`define SIG_W     14   // Sample width on the stream path
`define KP_W      12   // Signed proportional gain
`define KP_SHIFT  8    // Product scaling, arithmetic right shift

// System bus, region in top 3 bits, offset below
`define SYS_AW    23
`define SYS_OFS_W 20
`define SYS_DW    32

// Housekeeping register offsets within region 0
`define REG_CFG   20'h00000  // Bit 0 digital loop
`define REG_GEN_A 20'h00004
`define REG_GEN_B 20'h00008
`define REG_SET_A 20'h0000C
`define REG_SET_B 20'h00010
`define REG_KP_A  20'h00014
`define REG_KP_B  20'h00018

`endif

/* logic/pitaya_pkg.sv */
`include "pitaya_defs.svh"

package pitaya_pkg;

  // Stream samples, two's complement
  typedef logic signed [`SIG_W-1:0] sig_t;

  // One guard bit for sums and differences
  typedef logic signed [`SIG_W:0] sum_t;

  // Raw ADC word as it arrives on the pins
  typedef logic [`ADC_RAW_W-1:0] adc_raw_t;

  // Controller gain
  typedef logic signed [`KP_W-1:0] kp_t;

  // System bus
  typedef logic [`SYS_AW-1:0] sys_addr_t;
  typedef logic [`SYS_DW-1:0] sys_data_t;

endpackage

/* logic/adc_front.sv */
`include "pitaya_defs.svh"

module adc_front (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  pitaya_pkg::adc_raw_t adc_a_raw_i,   // Channel A pins
  input  pitaya_pkg::adc_raw_t adc_b_raw_i,   // Channel B pins
  input  pitaya_pkg::sig_t    loop_a_i,       // Saturated DAC-bound value A
  input  pitaya_pkg::sig_t    loop_b_i,       // Saturated DAC-bound value B
  input  logic                digital_loop_i,
  output pitaya_pkg::sig_t    adc_a_o,
  output pitaya_pkg::sig_t    adc_b_o
);

  import pitaya_pkg::*;

  logic [`SIG_W-1:0] raw_a_q;  // Negative-slope code, reserved bits gone
  logic [`SIG_W-1:0] raw_b_q;
  sig_t              conv_a;
  sig_t              conv_b;

  //////////////////////////////
  // Input registers
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      // Lowest two bits are reserved on the 16-bit bus
      raw_a_q <= adc_a_raw_i[`ADC_RAW_W-1 -: `SIG_W];
      raw_b_q <= adc_b_raw_i[`ADC_RAW_W-1 -: `SIG_W];
    end
  end

  // Negative slope to two's complement, MSB kept
  assign conv_a = {raw_a_q[`SIG_W-1], ~raw_a_q[`SIG_W-2:0]};
  assign conv_b = {raw_b_q[`SIG_W-1], ~raw_b_q[`SIG_W-2:0]};

  // Loopback bypasses the converter
  assign adc_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign adc_b_o = digital_loop_i ? loop_b_i : conv_b;

endmodule

/* logic/hk_regs.sv */
`include "pitaya_defs.svh"

module hk_regs (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // System bus
  input  pitaya_pkg::sys_addr_t sys_addr_i,
  input  pitaya_pkg::sys_data_t sys_wdata_i,
  input  logic                  sys_wen_i,     // Single-cycle write strobe
  input  logic                  sys_ren_i,     // Single-cycle read strobe
  output pitaya_pkg::sys_data_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // Configuration levels
  output logic                  digital_loop_o,
  output pitaya_pkg::sig_t      gen_a_o,
  output pitaya_pkg::sig_t      gen_b_o,
  output pitaya_pkg::sig_t      set_a_o,
  output pitaya_pkg::sig_t      set_b_o,
  output pitaya_pkg::kp_t       kp_a_o,
  output pitaya_pkg::kp_t       kp_b_o
);

  import pitaya_pkg::*;

  logic [`SYS_AW-`SYS_OFS_W-1:0] region;
  logic [`SYS_OFS_W-1:0]         offset;
  logic                          in_reg0;  // Only region 0 is mapped
  logic                          req;
  logic                          wr_en;
  logic                          cfg_q;
  sig_t                          gen_a_q, gen_b_q;
  sig_t                          set_a_q, set_b_q;
  kp_t                           kp_a_q, kp_b_q;
  sys_data_t                     rd_mux;

  assign region  = sys_addr_i[`SYS_AW-1:`SYS_OFS_W];
  assign offset  = sys_addr_i[`SYS_OFS_W-1:0];
  assign in_reg0 = (region == '0);
  assign req     = sys_wen_i || sys_ren_i;
  assign wr_en   = sys_wen_i && in_reg0;  // Other regions drop writes

  //////////////////////////////
  // Register bank
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cfg_q   <= 1'b0;
      gen_a_q <= '0;
      gen_b_q <= '0;
      set_a_q <= '0;
      set_b_q <= '0;
      kp_a_q  <= '0;
      kp_b_q  <= '0;
    end
    else if (wr_en)
    begin
      // Low bits of the data word only
      case (offset)
        `REG_CFG   : cfg_q   <= sys_wdata_i[0];
        `REG_GEN_A : gen_a_q <= sys_wdata_i[`SIG_W-1:0];
        `REG_GEN_B : gen_b_q <= sys_wdata_i[`SIG_W-1:0];
        `REG_SET_A : set_a_q <= sys_wdata_i[`SIG_W-1:0];
        `REG_SET_B : set_b_q <= sys_wdata_i[`SIG_W-1:0];
        `REG_KP_A  : kp_a_q  <= sys_wdata_i[`KP_W-1:0];
        `REG_KP_B  : kp_b_q  <= sys_wdata_i[`KP_W-1:0];
        default    : ;  // Unknown offset, nothing stored
      endcase
    end
  end

  // Read mux, signed sources extend with their sign
  always_comb
  begin
    rd_mux = '0;
    case (offset)
      `REG_CFG   : rd_mux = {{(`SYS_DW-1){1'b0}}, cfg_q};
      `REG_GEN_A : rd_mux = gen_a_q;
      `REG_GEN_B : rd_mux = gen_b_q;
      `REG_SET_A : rd_mux = set_a_q;
      `REG_SET_B : rd_mux = set_b_q;
      `REG_KP_A  : rd_mux = kp_a_q;
      `REG_KP_B  : rd_mux = kp_b_q;
      default    : rd_mux = '0;
    endcase
  end

  //////////////////////////////
  // Bus response, one cycle later
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end
    else
    begin
      sys_ack_o   <= req && in_reg0;
      sys_err_o   <= req && !in_reg0;   // Stub behaviour for regions 1..7
      sys_rdata_o <= (sys_ren_i && in_reg0) ? rd_mux : '0;
    end
  end

  assign digital_loop_o = cfg_q;
  assign gen_a_o        = gen_a_q;
  assign gen_b_o        = gen_b_q;
  assign set_a_o        = set_a_q;
  assign set_b_o        = set_b_q;
  assign kp_a_o         = kp_a_q;
  assign kp_b_o         = kp_b_q;

  // Protocol checks
  a_ack_err_excl : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_ack_o && sys_err_o));
  a_resp_after_req : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_ack_o || sys_err_o) |-> $past(sys_wen_i || sys_ren_i));
  a_one_strobe : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i));

endmodule

/* logic/p_ctrl.sv */
`include "pitaya_defs.svh"

module p_ctrl (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  pitaya_pkg::sig_t dat_i,    // Measured value
  input  pitaya_pkg::sig_t set_i,    // Setpoint
  input  pitaya_pkg::kp_t  kp_i,     // Proportional gain
  output pitaya_pkg::sig_t ctrl_o
);

  import pitaya_pkg::*;

  // Error times gain, full precision
  localparam int PROD_W = `SIG_W + 1 + `KP_W;

  sum_t                     err_q;
  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] prod_sh;
  logic                     ovf;
  sig_t                     sat;
  sig_t                     ctrl_q;

  //////////////////////////////
  // Stage 1, error
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      err_q <= '0;
    else
      err_q <= set_i - dat_i;  // 15 bits, cannot wrap
  end

  assign prod    = err_q * kp_i;
  assign prod_sh = prod >>> `KP_SHIFT;  // Keeps sign

  // Anything above the 14-bit sign position must be a sign copy
  assign ovf = (prod_sh[PROD_W-1:`SIG_W-1] !=
                {(PROD_W-`SIG_W+1){prod_sh[PROD_W-1]}});

  // Clip to the extreme of the product sign
  assign sat = ovf ? {prod_sh[PROD_W-1], {(`SIG_W-1){~prod_sh[PROD_W-1]}}}
                   : prod_sh[`SIG_W-1:0];

  //////////////////////////////
  // Stage 2, scaled output
  //////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      ctrl_q <= '0;
    else
      ctrl_q <= sat;
  end

  assign ctrl_o = ctrl_q;

endmodule

/* logic/dac_out.sv */
`include "pitaya_defs.svh"

module dac_out (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  pitaya_pkg::sig_t  gen_a_i,    // DC generator levels
  input  pitaya_pkg::sig_t  gen_b_i,
  input  pitaya_pkg::sig_t  ctrl_a_i,   // Controller outputs
  input  pitaya_pkg::sig_t  ctrl_b_i,
  output pitaya_pkg::sig_t  loop_a_o,   // Back to the input side
  output pitaya_pkg::sig_t  loop_b_o,
  output logic [`SIG_W-1:0] dac_a_o,    // Offset negative-slope code
  output logic [`SIG_W-1:0] dac_b_o
);

  import pitaya_pkg::*;

  sum_t sum_a, sum_b;
  sig_t sat_a, sat_b;

  // Top two bits differ means overflow past 14 bits
  function automatic sig_t sat_sum(input sum_t s);
    return (^s[`SIG_W:`SIG_W-1]) ? {s[`SIG_W], {(`SIG_W-1){~s[`SIG_W]}}}
                                 : s[`SIG_W-1:0];
  endfunction

  // Sign stays, rest inverted; zero maps to 0x1FFF
  function automatic logic [`SIG_W-1:0] dac_code(input sig_t v);
    return {v[`SIG_W-1], ~v[`SIG_W-2:0]};
  endfunction

  assign sum_a = gen_a_i + ctrl_a_i;
  assign sum_b = gen_b_i + ctrl_b_i;
  assign sat_a = sat_sum(sum_a);
  assign sat_b = sat_sum(sum_b);

  assign loop_a_o = sat_a;
  assign loop_b_o = sat_b;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_a_o <= dac_code('0);  // Code for zero
      dac_b_o <= dac_code('0);
    end
    else
    begin
      dac_a_o <= dac_code(sat_a);
      dac_b_o <= dac_code(sat_b);
    end
  end

  a_dac_code : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (dac_a_o == dac_code($past(sat_a))) &&
                       (dac_b_o == dac_code($past(sat_b))));

endmodule

/* logic/pitaya_core.sv */
`include "pitaya_defs.svh"

module pitaya_core (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // ADC pins
  input  pitaya_pkg::adc_raw_t  adc_a_i,
  input  pitaya_pkg::adc_raw_t  adc_b_i,
  // System bus
  input  pitaya_pkg::sys_addr_t sys_addr_i,
  input  pitaya_pkg::sys_data_t sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output pitaya_pkg::sys_data_t sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // DAC data, one port per channel
  output logic [`SIG_W-1:0]     dac_a_o,
  output logic [`SIG_W-1:0]     dac_b_o
);

  import pitaya_pkg::*;

  sig_t adc_a, adc_b;            // Two's complement samples
  sig_t ctrl_out_a, ctrl_out_b;
  sig_t loop_a, loop_b;          // Saturated sums
  logic digital_loop;
  sig_t gen_a, gen_b;
  sig_t set_a, set_b;
  kp_t  kp_a, kp_b;

  //////////////////////////////
  // Input side
  //////////////////////////////
  adc_front i_adc (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_a_raw_i    (adc_a_i     ),
    .adc_b_raw_i    (adc_b_i     ),
    .loop_a_i       (loop_a      ),
    .loop_b_i       (loop_b      ),
    .digital_loop_i (digital_loop),
    .adc_a_o        (adc_a       ),
    .adc_b_o        (adc_b       )
  );

  // Housekeeping, the only mapped region
  hk_regs i_hk (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .sys_addr_i     (sys_addr_i  ),
    .sys_wdata_i    (sys_wdata_i ),
    .sys_wen_i      (sys_wen_i   ),
    .sys_ren_i      (sys_ren_i   ),
    .sys_rdata_o    (sys_rdata_o ),
    .sys_ack_o      (sys_ack_o   ),
    .sys_err_o      (sys_err_o   ),
    .digital_loop_o (digital_loop),
    .gen_a_o        (gen_a       ),
    .gen_b_o        (gen_b       ),
    .set_a_o        (set_a       ),
    .set_b_o        (set_b       ),
    .kp_a_o         (kp_a        ),
    .kp_b_o         (kp_b        )
  );

  // One controller per channel, no cross terms
  p_ctrl ctrl_a (.adc_clk(adc_clk), .rst_n_i(rst_n_i), .dat_i(adc_a), .set_i(set_a),
                 .kp_i(kp_a), .ctrl_o(ctrl_out_a));
  p_ctrl ctrl_b (.adc_clk(adc_clk), .rst_n_i(rst_n_i), .dat_i(adc_b), .set_i(set_b),
                 .kp_i(kp_b), .ctrl_o(ctrl_out_b));

  //////////////////////////////
  // Output side
  //////////////////////////////
  dac_out i_dac (
    .adc_clk  (adc_clk   ),
    .rst_n_i  (rst_n_i   ),
    .gen_a_i  (gen_a     ),
    .gen_b_i  (gen_b     ),
    .ctrl_a_i (ctrl_out_a),
    .ctrl_b_i (ctrl_out_b),
    .loop_a_o (loop_a    ),  // Feeds loopback mux
    .loop_b_o (loop_b    ),
    .dac_a_o  (dac_a_o   ),
    .dac_b_o  (dac_b_o   )
  );

endmodule

/* bench/tb_checker.sv */
`include "pitaya_defs.svh"

module tb_checker (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  pitaya_pkg::adc_raw_t  adc_a_i,
  input  pitaya_pkg::adc_raw_t  adc_b_i,
  input  pitaya_pkg::sys_addr_t sys_addr_i,
  input  pitaya_pkg::sys_data_t sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  input  pitaya_pkg::sys_data_t sys_rdata_i,
  input  logic                  sys_ack_i,
  input  logic                  sys_err_i,
  input  logic [`SIG_W-1:0]     dac_a_i,
  input  logic [`SIG_W-1:0]     dac_b_i,
  output int                    checks_o,
  output int                    errors_o
);

  import pitaya_pkg::*;

  localparam int SIG_MAX = (1 << (`SIG_W - 1)) - 1;
  localparam int SIG_MIN = -(1 << (`SIG_W - 1));

  // Shadow register map
  logic              cfg_m;
  int                gen_a_m, gen_b_m, set_a_m, set_b_m, kp_a_m, kp_b_m;
  // Stream model, one variable per pipeline register
  logic [`SIG_W-1:0] raw_a_m, raw_b_m;   // 14-bit ADC code
  int                err_a_m, err_b_m;   // Setpoint minus input
  int                ctl_a_m, ctl_b_m;   // Scaled controller output
  logic [`SIG_W-1:0] dac_a_m, dac_b_m;
  logic              ack_m, err_m, rd_m; // Expected bus response
  sys_data_t         rdata_m;
  logic              primed = 1'b0;      // Set by the first reset edge
  int                n_checks = 0;
  int                n_errors = 0;
  int                sum_a, sum_b;       // Loop values
  int                in_a, in_b;

  assign checks_o = n_checks;
  assign errors_o = n_errors;

  function automatic int clip(input int v);
    if (v > SIG_MAX)
      return SIG_MAX;
    if (v < SIG_MIN)
      return SIG_MIN;
    return v;
  endfunction

  // Low bits of a bus word as a signed field
  function automatic int field(input sys_data_t w, input int bits);
    int v;
    v = int'(w & ((32'd1 << bits) - 32'd1));
    if (w[bits-1])
      v = v - (1 << bits);
    return v;
  endfunction

  // Code falls by one per LSB, zero sits at 0x1FFF
  function automatic logic [`SIG_W-1:0] to_code(input int v);
    int c;
    c = SIG_MAX - v;
    return c[`SIG_W-1:0];
  endfunction

  function automatic int from_code(input logic [`SIG_W-1:0] c);
    return SIG_MAX - int'(c);
  endfunction

  function automatic sys_data_t read_value(input logic [`SYS_OFS_W-1:0] ofs);
    case (ofs)
      `REG_CFG   : return {{(`SYS_DW-1){1'b0}}, cfg_m};
      `REG_GEN_A : return gen_a_m;  // Signed fields come back sign-extended
      `REG_GEN_B : return gen_b_m;
      `REG_SET_A : return set_a_m;
      `REG_SET_B : return set_b_m;
      `REG_KP_A  : return kp_a_m;
      `REG_KP_B  : return kp_b_m;
      default    : return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input sys_data_t got, input sys_data_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      if (exp)
        $display("Missing %s one cycle after a bus request, at %0t", what, $time);
      else
        $display("Unexpected %s at %0t, no request called for one", what, $time);
    end
  endtask

  task automatic reset_model();
    cfg_m   = 1'b0;
    gen_a_m = 0;
    gen_b_m = 0;
    set_a_m = 0;
    set_b_m = 0;
    kp_a_m  = 0;
    kp_b_m  = 0;
    raw_a_m = '0;
    raw_b_m = '0;
    err_a_m = 0;
    err_b_m = 0;
    ctl_a_m = 0;
    ctl_b_m = 0;
    dac_a_m = to_code(0);
    dac_b_m = to_code(0);
    ack_m   = 1'b0;
    err_m   = 1'b0;
    rd_m    = 1'b0;
    rdata_m = '0;
    primed  = 1'b1;
  endtask

  task automatic step_model();
    logic [`SYS_AW-`SYS_OFS_W-1:0] region;
    logic [`SYS_OFS_W-1:0]         ofs;
    region = sys_addr_i[`SYS_AW-1:`SYS_OFS_W];
    ofs    = sys_addr_i[`SYS_OFS_W-1:0];
    // Loop values and input select, all from state before the edge
    sum_a = clip(gen_a_m + ctl_a_m);
    sum_b = clip(gen_b_m + ctl_b_m);
    in_a  = cfg_m ? sum_a : from_code(raw_a_m);
    in_b  = cfg_m ? sum_b : from_code(raw_b_m);
    // Pipeline advances from the back
    dac_a_m = to_code(sum_a);
    dac_b_m = to_code(sum_b);
    ctl_a_m = clip((err_a_m * kp_a_m) >>> `KP_SHIFT);
    ctl_b_m = clip((err_b_m * kp_b_m) >>> `KP_SHIFT);
    err_a_m = set_a_m - in_a;
    err_b_m = set_b_m - in_b;
    raw_a_m = adc_a_i[`ADC_RAW_W-1:2];  // Reserved LSBs dropped
    raw_b_m = adc_b_i[`ADC_RAW_W-1:2];
    // Bus response, reads see the registers before this edge
    ack_m   = (sys_wen_i || sys_ren_i) && (region == '0);
    err_m   = (sys_wen_i || sys_ren_i) && (region != '0);
    rd_m    = sys_ren_i;
    rdata_m = read_value(ofs);
    if (sys_wen_i && (region == '0))
    begin
      case (ofs)
        `REG_CFG   : cfg_m   = sys_wdata_i[0];
        `REG_GEN_A : gen_a_m = field(sys_wdata_i, `SIG_W);
        `REG_GEN_B : gen_b_m = field(sys_wdata_i, `SIG_W);
        `REG_SET_A : set_a_m = field(sys_wdata_i, `SIG_W);
        `REG_SET_B : set_b_m = field(sys_wdata_i, `SIG_W);
        `REG_KP_A  : kp_a_m  = field(sys_wdata_i, `KP_W);
        `REG_KP_B  : kp_b_m  = field(sys_wdata_i, `KP_W);
        default    : ;
      endcase
    end
  endtask

  //////////////////////////////
  // Compare, then advance
  //////////////////////////////
  always @(posedge adc_clk)
  begin
    if (primed)
    begin
      check_value("dac_a_o", sys_data_t'(dac_a_i), sys_data_t'(dac_a_m));
      check_value("dac_b_o", sys_data_t'(dac_b_i), sys_data_t'(dac_b_m));
      check_flag("acknowledge", sys_ack_i, ack_m);
      check_flag("error response", sys_err_i, err_m);
      if (rd_m && ack_m)
        check_value("sys_rdata_o", sys_rdata_i, rdata_m);  // Read data only on read acks
    end
    if (!rst_n_i)
      reset_model();
    else
      step_model();
  end

endmodule

/* bench/tb_top.sv */
`include "pitaya_defs.svh"

module tb_top;

  import pitaya_pkg::*;

  localparam logic [15:0] SEED = 16'd15391;
  localparam int DRAIN     = 6;   // Idle cycles so the pipeline empties
  localparam int BUS_CYC   = 4;   // Upper bound per bus access
  localparam int N_REG_RND = 3;
  localparam int N_FF_RND  = 4;
  localparam int N_FF      = 50;
  localparam int N_CT_RND  = 4;
  localparam int N_CT      = 80;
  localparam int N_LP_RND  = 3;
  localparam int N_LP      = 60;
  // Cycle budget, one term per test plus margin
  localparam int LIMIT = (4 + 8 + DRAIN)
                       + (N_REG_RND * 18 * BUS_CYC + DRAIN)
                       + (21 * BUS_CYC + DRAIN)
                       + ((3 + 2 * N_FF_RND) * BUS_CYC + N_FF_RND * N_FF + DRAIN)
                       + (N_CT_RND * (7 * BUS_CYC + N_CT) + DRAIN)
                       + (N_LP_RND * (7 * BUS_CYC + N_LP) + BUS_CYC + DRAIN)
                       + 100;
  localparam logic [`SYS_OFS_W-1:0] REG_OFS [7] = '{`REG_CFG, `REG_GEN_A, `REG_GEN_B,
                                                     `REG_SET_A, `REG_SET_B, `REG_KP_A,
                                                     `REG_KP_B};

  logic              adc_clk = 1'b0;
  logic              rst_n;
  adc_raw_t          adc_a, adc_b;
  sys_addr_t         sys_addr;
  sys_data_t         sys_wdata;
  logic              sys_wen, sys_ren;
  sys_data_t         sys_rdata;
  logic              sys_ack, sys_err;
  logic [`SIG_W-1:0] dac_a, dac_b;
  int                checks, errors;
  int                bus_fails = 0;   // Requests with no response at all
  int                cycle = 0;
  int                chk_mark = 0;
  int                err_mark = 0;
  logic [15:0]       lfsr_q = SEED;

  always #2 adc_clk = ~adc_clk;

  pitaya_core DUT (
    .adc_clk(adc_clk), .rst_n_i(rst_n), .adc_a_i(adc_a), .adc_b_i(adc_b),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen),
    .sys_ren_i(sys_ren), .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack),
    .sys_err_o(sys_err), .dac_a_o(dac_a), .dac_b_o(dac_b)
  );

  tb_checker i_chk (
    .adc_clk(adc_clk), .rst_n_i(rst_n), .adc_a_i(adc_a), .adc_b_i(adc_b),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata), .sys_wen_i(sys_wen),
    .sys_ren_i(sys_ren), .sys_rdata_i(sys_rdata), .sys_ack_i(sys_ack),
    .sys_err_i(sys_err), .dac_a_i(dac_a), .dac_b_i(dac_b),
    .checks_o(checks), .errors_o(errors)
  );

  // Fibonacci form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);  // One step per bit
    end
  endtask

  //////////////////////////////
  // Bus access
  //////////////////////////////
  task automatic bus_access(input logic wr, input logic [2:0] region,
                            input logic [`SYS_OFS_W-1:0] ofs, input sys_data_t data);
    int waited;
    @(posedge adc_clk);
    sys_addr  <= {region, ofs};
    sys_wdata <= data;
    sys_wen   <= wr;
    sys_ren   <= !wr;
    @(posedge adc_clk);
    sys_wen   <= 1'b0;   // Single-cycle strobe
    sys_ren   <= 1'b0;
    waited = 0;
    @(negedge adc_clk);
    while (!(sys_ack || sys_err) && waited < BUS_CYC)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!(sys_ack || sys_err))
    begin
      bus_fails++;
      $display("No bus response to %s at region %0d offset 0x%05h",
               wr ? "write" : "read", region, ofs);
    end
  endtask

  task automatic bus_write(input logic [2:0] region, input logic [`SYS_OFS_W-1:0] ofs,
                           input sys_data_t data);
    bus_access(1'b1, region, ofs, data);
  endtask

  task automatic bus_read(input logic [2:0] region, input logic [`SYS_OFS_W-1:0] ofs);
    bus_access(1'b0, region, ofs, '0);
  endtask

  // Random ADC words every cycle
  task automatic stream(input int n);
    logic [31:0] r;
    repeat (n)
    begin
      @(posedge adc_clk);
      rand_bits(`ADC_RAW_W, r);
      adc_a <= r[`ADC_RAW_W-1:0];
      rand_bits(`ADC_RAW_W, r);
      adc_b <= r[`ADC_RAW_W-1:0];
    end
  endtask

  task automatic write_random(input logic [`SYS_OFS_W-1:0] ofs);
    logic [31:0] r;
    rand_bits(32, r);
    bus_write(3'd0, ofs, r);
  endtask

  task automatic end_test(input string name);
    repeat (DRAIN) @(posedge adc_clk);
    @(negedge adc_clk);  // Counts from the last edge are in
    $display("Test %s finished: %0d checks, %0d errors", name, checks - chk_mark,
             errors + bus_fails - err_mark);
    chk_mark = checks;
    err_mark = errors + bus_fails;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial
  begin
    logic [31:0] r;
    int          k;
    int          i;
    rst_n     = 1'b0;
    adc_a     = '0;
    adc_b     = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    repeat (4) @(posedge adc_clk);
    rst_n <= 1'b1;
    repeat (8) @(posedge adc_clk);
    end_test("reset");

    // Full-width random data, fields keep their low bits
    for (k = 0; k < N_REG_RND; k++)
    begin
      for (i = 0; i < 7; i++)
        write_random(REG_OFS[i]);
      for (i = 0; i < 7; i++)
        bus_read(3'd0, REG_OFS[i]);
      bus_read(3'd0, 20'h0001C);
      bus_read(3'd0, 20'h00020);
      bus_read(3'd0, 20'hFFFFC);
      rand_bits(17, r);
      bus_read(3'd0, {1'b1, r[16:0], 2'b00});  // Never a mapped offset
    end
    end_test("registers");

    for (k = 1; k < 8; k++)
    begin
      rand_bits(3, r);
      i = r % 7;
      rand_bits(32, r);
      bus_write(k[2:0], REG_OFS[i], r);
      bus_read(k[2:0], REG_OFS[i]);
    end
    for (i = 0; i < 7; i++)
      bus_read(3'd0, REG_OFS[i]);   // Unchanged by the stray writes
    end_test("unmapped");

    bus_write(3'd0, `REG_CFG, 32'd0);
    bus_write(3'd0, `REG_KP_A, 32'd0);
    bus_write(3'd0, `REG_KP_B, 32'd0);
    for (k = 0; k < N_FF_RND; k++)
    begin
      write_random(`REG_GEN_A);
      write_random(`REG_GEN_B);
      stream(N_FF);
    end
    end_test("feedforward");

    for (k = 0; k < N_CT_RND; k++)
    begin
      bus_write(3'd0, `REG_CFG, 32'd0);
      for (i = 1; i < 7; i++)
        write_random(REG_OFS[i]);
      stream(N_CT);
    end
    end_test("controller");

    // ADC words keep changing but the loop ignores them
    for (k = 0; k < N_LP_RND; k++)
    begin
      for (i = 1; i < 7; i++)
        write_random(REG_OFS[i]);
      bus_write(3'd0, `REG_CFG, 32'd1);
      stream(N_LP);
    end
    bus_write(3'd0, `REG_CFG, 32'd0);
    end_test("loopback");

    $display("Totals: %0d checks, %0d errors", checks, errors + bus_fails);
    if (errors + bus_fails == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  always @(posedge adc_clk)
  begin
    cycle++;
    if (cycle >= LIMIT)
    begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

/* pitaya_core.f */
+incdir+logic
logic/pitaya_pkg.sv
logic/adc_front.sv
logic/hk_regs.sv
logic/p_ctrl.sv
logic/dac_out.sv
logic/pitaya_core.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_top -f pitaya_core.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log
if grep -qx "Simulation passed" sim.log; then
  exit 0
fi
exit 1
